//--- verilog/controlPkg.sv
`default_nettype none

package controlPkg;

	typedef enum logic [6:0]
	{
		opcLoad   = 7'b0000011,
		opcFLoad  = 7'b0000111,
		opcOpImm  = 7'b0010011,
		opcAuipc  = 7'b0010111,
		opcStore  = 7'b0100011,
		opcFStore = 7'b0100111,
		opcRType  = 7'b0110011,
		opcLui    = 7'b0110111,
		opcFRType = 7'b1010011,
		opcBranch = 7'b1100011,
		opcJalr   = 7'b1100111,
		opcJal    = 7'b1101111
	} opcodeE;

	typedef enum logic [4:0]
	{
		opNull, opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd, opLui,
		opMul, opMulh, opMulhsu, opMulhu, opDiv, opDivu, opRem, opRemu
	} aluOpE;

	typedef enum logic [4:0]
	{
		fopNull, fopAdd, fopSub, fopMul, fopDiv, fopSqrt, fopMv, fopSgnj, fopSgnjn, fopSgnjx,
		fopMax, fopMin, fopCeq, fopCle, fopClt, fopCvtSW, fopCvtSWu, fopCvtWS, fopCvtWuS
	} fpuOpE;

	typedef enum logic [1:0]
	{
		wbAlu = 2'b00,
		wbPc4 = 2'b01, // Link address for JAL and JALR
		wbMem = 2'b10
	} mem2RegE;

	typedef enum logic [1:0]
	{
		pcPlus4  = 2'b00,
		pcBranch = 2'b01,
		pcJal    = 2'b10,
		pcJalr   = 2'b11
	} origPcE;

	localparam logic [6:0] funct7Base    = 7'b0000000;
	localparam logic [6:0] funct7Sub     = 7'b0100000; // Also selects SRA and SRAI
	localparam logic [6:0] funct7MulDiv  = 7'b0000001;
	localparam logic [6:0] funct7FAdd    = 7'b0000000;
	localparam logic [6:0] funct7FSub    = 7'b0000100;
	localparam logic [6:0] funct7FMul    = 7'b0001000;
	localparam logic [6:0] funct7FDiv    = 7'b0001100;
	localparam logic [6:0] funct7FSqrt   = 7'b0101100;
	localparam logic [6:0] funct7FSgnj   = 7'b0010000;
	localparam logic [6:0] funct7FMinMax = 7'b0010100;
	localparam logic [6:0] funct7FCmp    = 7'b1010000;
	localparam logic [6:0] funct7FCvtWS  = 7'b1100000; // Float to integer
	localparam logic [6:0] funct7FCvtSW  = 7'b1101000; // Integer to float
	localparam logic [6:0] funct7FMvXS   = 7'b1110000;
	localparam logic [6:0] funct7FMvSX   = 7'b1111000;

	localparam logic [4:0] rs2CvtSigned   = 5'b00000;
	localparam logic [4:0] rs2CvtUnsigned = 5'b00001;

	localparam logic [31:0] causeIllegal = 32'd2;

endpackage

`default_nettype wire

//--- verilog/ctrlBus.sv
`timescale 1ns/100ps
`default_nettype none

interface ctrlBus;
	logic                hit;     // Opcode owned by this decoder
	logic                illegal; // Unlisted sub-field
	logic                origAAlu;
	logic                origBAlu;
	logic                regWrite;
	logic                memWrite;
	logic                memRead;
	controlPkg::mem2RegE mem2Reg;
	controlPkg::origPcE  origPc;
	controlPkg::aluOpE   aluOp;
	logic                fRegWrite;
	controlPkg::fpuOpE   fpuOp;
	logic                origAFpu;
	logic                fpu2Reg;
	logic                fWriteData;
	logic                write2Mem;
	logic                fpStart;

	modport source (output hit, illegal, origAAlu, origBAlu, regWrite, memWrite, memRead,
		mem2Reg, origPc, aluOp, fRegWrite, fpuOp, origAFpu, fpu2Reg, fWriteData, write2Mem,
		fpStart);

	modport sink (input hit, illegal, origAAlu, origBAlu, regWrite, memWrite, memRead,
		mem2Reg, origPc, aluOp, fRegWrite, fpuOp, origAFpu, fpu2Reg, fWriteData, write2Mem,
		fpStart);
endinterface

`default_nettype wire

//--- verilog/intDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module intDecoder #(
	parameter bit enableMulDiv = 1'b1
) (
	input wire logic [31:0] instr,
	ctrlBus.source          bus
);

	controlPkg::opcodeE opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;

	assign opcode = controlPkg::opcodeE'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Shared by OP-IMM and R-type; immediates have no SUB
	function automatic controlPkg::aluOpE baseOp(input logic [2:0] f3, input logic alt,
		input logic allowSub);
		case (f3)
			3'b000:  baseOp = (alt && allowSub) ? controlPkg::opSub : controlPkg::opAdd;
			3'b001:  baseOp = controlPkg::opSll;
			3'b010:  baseOp = controlPkg::opSlt;
			3'b011:  baseOp = controlPkg::opSltu;
			3'b100:  baseOp = controlPkg::opXor;
			3'b101:  baseOp = alt ? controlPkg::opSra : controlPkg::opSrl;
			3'b110:  baseOp = controlPkg::opOr;
			default: baseOp = controlPkg::opAnd;
		endcase
	endfunction

	always_comb
	begin
		bus.hit        = 1'b1;
		bus.illegal    = 1'b0;
		bus.origAAlu   = 1'b0;
		bus.origBAlu   = 1'b0;
		bus.regWrite   = 1'b0;
		bus.memWrite   = 1'b0;
		bus.memRead    = 1'b0;
		bus.mem2Reg    = controlPkg::wbAlu;
		bus.origPc     = controlPkg::pcPlus4;
		bus.aluOp      = controlPkg::opAdd;
		bus.fRegWrite  = 1'b0; // FP side stays idle here
		bus.fpuOp      = controlPkg::fopNull;
		bus.origAFpu   = 1'b0;
		bus.fpu2Reg    = 1'b0;
		bus.fWriteData = 1'b0;
		bus.write2Mem  = 1'b0;
		bus.fpStart    = 1'b0;
		case (opcode)
			controlPkg::opcLoad:
			begin
				bus.origBAlu = 1'b1;
				bus.regWrite = 1'b1;
				bus.memRead  = 1'b1;
				bus.mem2Reg  = controlPkg::wbMem;
			end
			controlPkg::opcOpImm:
			begin
				bus.origBAlu = 1'b1;
				bus.regWrite = 1'b1;
				bus.aluOp    = baseOp(funct3, funct7 == controlPkg::funct7Sub, 1'b0);
			end
			controlPkg::opcAuipc:
			begin
				bus.origAAlu = 1'b1; // PC as operand A
				bus.origBAlu = 1'b1;
				bus.regWrite = 1'b1;
			end
			controlPkg::opcStore:
			begin
				bus.origBAlu = 1'b1;
				bus.memWrite = 1'b1;
			end
			controlPkg::opcRType:
			begin
				bus.regWrite = 1'b1;
				case (funct7)
					controlPkg::funct7Base,
					controlPkg::funct7Sub:
						bus.aluOp = baseOp(funct3, funct7 == controlPkg::funct7Sub, 1'b1);
					controlPkg::funct7MulDiv:
						if (enableMulDiv)
						begin
							case (funct3)
								3'b000:  bus.aluOp = controlPkg::opMul;
								3'b001:  bus.aluOp = controlPkg::opMulh;
								3'b010:  bus.aluOp = controlPkg::opMulhsu;
								3'b011:  bus.aluOp = controlPkg::opMulhu;
								3'b100:  bus.aluOp = controlPkg::opDiv;
								3'b101:  bus.aluOp = controlPkg::opDivu;
								3'b110:  bus.aluOp = controlPkg::opRem;
								default: bus.aluOp = controlPkg::opRemu;
							endcase
						end
						else
							bus.illegal = 1'b1; // M extension not built
					default: bus.illegal = 1'b1;
				endcase
			end
			controlPkg::opcLui:
			begin
				bus.origBAlu = 1'b1;
				bus.regWrite = 1'b1;
				bus.aluOp    = controlPkg::opLui;
			end
			controlPkg::opcBranch: bus.origPc = controlPkg::pcBranch;
			controlPkg::opcJalr:
			begin
				bus.regWrite = 1'b1;
				bus.mem2Reg  = controlPkg::wbPc4;
				bus.origPc   = controlPkg::pcJalr;
			end
			controlPkg::opcJal:
			begin
				bus.regWrite = 1'b1;
				bus.mem2Reg  = controlPkg::wbPc4;
				bus.origPc   = controlPkg::pcJal;
			end
			default:
			begin
				bus.hit   = 1'b0;
				bus.aluOp = controlPkg::opNull;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/fpDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module fpDecoder #(
	parameter bit enableFloat = 1'b1
) (
	input wire logic [31:0] instr,
	ctrlBus.source          bus
);

	controlPkg::opcodeE opcode;
	logic [2:0]         funct3;
	logic [4:0]         rs2;
	logic [6:0]         funct7;

	assign opcode = controlPkg::opcodeE'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rs2    = instr[24:20]; // Convert variant selector
	assign funct7 = instr[31:25];

	always_comb
	begin : decode
		logic owned;
		logic bad;
		logic toInt; // Result goes to the integer file

		owned          = 1'b1;
		bad            = 1'b0;
		toInt          = 1'b0;
		bus.origAAlu   = 1'b0;
		bus.origBAlu   = 1'b0;
		bus.regWrite   = 1'b0;
		bus.memWrite   = 1'b0;
		bus.memRead    = 1'b0;
		bus.mem2Reg    = controlPkg::wbAlu;
		bus.origPc     = controlPkg::pcPlus4;
		bus.aluOp      = controlPkg::opNull;
		bus.fRegWrite  = 1'b0;
		bus.fpuOp      = controlPkg::fopNull;
		bus.origAFpu   = 1'b0;
		bus.fpu2Reg    = 1'b0;
		bus.fWriteData = 1'b0;
		bus.write2Mem  = 1'b0;
		bus.fpStart    = 1'b0;
		case (opcode)
			controlPkg::opcFRType:
			begin
				bus.fpStart  = 1'b1;
				bus.origAFpu = 1'b1;
				case (funct7)
					controlPkg::funct7FAdd:  bus.fpuOp = controlPkg::fopAdd;
					controlPkg::funct7FSub:  bus.fpuOp = controlPkg::fopSub;
					controlPkg::funct7FMul:  bus.fpuOp = controlPkg::fopMul;
					controlPkg::funct7FDiv:  bus.fpuOp = controlPkg::fopDiv;
					controlPkg::funct7FSqrt: bus.fpuOp = controlPkg::fopSqrt;
					controlPkg::funct7FMvSX:
					begin
						bus.fpuOp    = controlPkg::fopMv;
						bus.origAFpu = 1'b0; // rs1 from integer file
					end
					controlPkg::funct7FMvXS:
					begin
						bus.fpuOp = controlPkg::fopMv;
						toInt     = 1'b1;
					end
					controlPkg::funct7FSgnj:
						case (funct3)
							3'b000:  bus.fpuOp = controlPkg::fopSgnj;
							3'b001:  bus.fpuOp = controlPkg::fopSgnjn;
							3'b010:  bus.fpuOp = controlPkg::fopSgnjx;
							default: bad = 1'b1;
						endcase
					controlPkg::funct7FMinMax:
						case (funct3)
							3'b000:  bus.fpuOp = controlPkg::fopMin;
							3'b001:  bus.fpuOp = controlPkg::fopMax;
							default: bad = 1'b1;
						endcase
					controlPkg::funct7FCmp:
					begin
						toInt = 1'b1;
						case (funct3)
							3'b000:  bus.fpuOp = controlPkg::fopCle;
							3'b001:  bus.fpuOp = controlPkg::fopClt;
							3'b010:  bus.fpuOp = controlPkg::fopCeq;
							default: bad = 1'b1;
						endcase
					end
					controlPkg::funct7FCvtSW:
					begin
						bus.origAFpu = 1'b0;
						case (rs2)
							controlPkg::rs2CvtSigned:   bus.fpuOp = controlPkg::fopCvtSW;
							controlPkg::rs2CvtUnsigned: bus.fpuOp = controlPkg::fopCvtSWu;
							default:                    bad = 1'b1;
						endcase
					end
					controlPkg::funct7FCvtWS:
					begin
						toInt = 1'b1;
						case (rs2)
							controlPkg::rs2CvtSigned:   bus.fpuOp = controlPkg::fopCvtWS;
							controlPkg::rs2CvtUnsigned: bus.fpuOp = controlPkg::fopCvtWuS;
							default:                    bad = 1'b1;
						endcase
					end
					default: bad = 1'b1;
				endcase
				bus.regWrite  = toInt;
				bus.fpu2Reg   = toInt;
				bus.fRegWrite = !toInt;
			end
			controlPkg::opcFLoad:
			begin
				bus.origBAlu   = 1'b1; // Address is rs1 + imm
				bus.memRead    = 1'b1;
				bus.mem2Reg    = controlPkg::wbMem;
				bus.aluOp      = controlPkg::opAdd;
				bus.fRegWrite  = 1'b1;
				bus.fWriteData = 1'b1; // FP register loaded from memory
			end
			controlPkg::opcFStore:
			begin
				bus.origBAlu  = 1'b1;
				bus.memWrite  = 1'b1;
				bus.aluOp     = controlPkg::opAdd;
				bus.write2Mem = 1'b1; // Store data from FP file
			end
			default: owned = 1'b0;
		endcase
		bus.hit     = owned && enableFloat;
		bus.illegal = bad && bus.hit;
	end

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
	input wire logic            clk,
	input wire logic            arstN,
	input wire logic            instrValid,
	ctrlBus.sink                intBus,
	ctrlBus.sink                fpBus,
	output logic                ctrlValid,
	output logic                origAAlu,
	output logic                origBAlu,
	output logic                regWrite,
	output logic                memWrite,
	output logic                memRead,
	output controlPkg::mem2RegE mem2Reg,
	output controlPkg::origPcE  origPc,
	output controlPkg::aluOpE   aluOp,
	output logic                fRegWrite,
	output controlPkg::fpuOpE   fpuOp,
	output logic                origAFpu,
	output logic                fpu2Reg,
	output logic                fWriteData,
	output logic                write2Mem,
	output logic                fpStart,
	output logic                pcOrUtvec,
	output logic                csrWrite,
	output logic [31:0]         ucause
);

	typedef struct packed {
		logic                origAAlu;
		logic                origBAlu;
		logic                regWrite;
		logic                memWrite;
		logic                memRead;
		controlPkg::mem2RegE mem2Reg;
		controlPkg::origPcE  origPc;
		controlPkg::aluOpE   aluOp;
		logic                fRegWrite;
		controlPkg::fpuOpE   fpuOp;
		logic                origAFpu;
		logic                fpu2Reg;
		logic                fWriteData;
		logic                write2Mem;
		logic                fpStart;
		logic                pcOrUtvec;
		logic                csrWrite;
	} bundleT;

	bundleT intB;
	bundleT fpB;
	bundleT nextB;
	bundleT regB;

	assign intB = '{intBus.origAAlu, intBus.origBAlu, intBus.regWrite, intBus.memWrite,
		intBus.memRead, intBus.mem2Reg, intBus.origPc, intBus.aluOp, intBus.fRegWrite,
		intBus.fpuOp, intBus.origAFpu, intBus.fpu2Reg, intBus.fWriteData, intBus.write2Mem,
		intBus.fpStart, 1'b0, 1'b0};
	assign fpB = '{fpBus.origAAlu, fpBus.origBAlu, fpBus.regWrite, fpBus.memWrite,
		fpBus.memRead, fpBus.mem2Reg, fpBus.origPc, fpBus.aluOp, fpBus.fRegWrite,
		fpBus.fpuOp, fpBus.origAFpu, fpBus.fpu2Reg, fpBus.fWriteData, fpBus.write2Mem,
		fpBus.fpStart, 1'b0, 1'b0};

	always_comb
	begin
		nextB = '0; // Idle bundle, also used for empty slots
		if (instrValid)
		begin
			if (intBus.hit && !intBus.illegal)
				nextB = intB;
			else if (fpBus.hit && !fpBus.illegal)
				nextB = fpB;
			else
			begin
				nextB.pcOrUtvec = 1'b1; // Jump to trap vector
				nextB.csrWrite  = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			ctrlValid <= 1'b0;
			regB      <= '0;
		end
		else
		begin
			ctrlValid <= instrValid;
			regB      <= nextB;
		end
	end

	assign origAAlu   = regB.origAAlu;
	assign origBAlu   = regB.origBAlu;
	assign regWrite   = regB.regWrite;
	assign memWrite   = regB.memWrite;
	assign memRead    = regB.memRead;
	assign mem2Reg    = regB.mem2Reg;
	assign origPc     = regB.origPc;
	assign aluOp      = regB.aluOp;
	assign fRegWrite  = regB.fRegWrite;
	assign fpuOp      = regB.fpuOp;
	assign origAFpu   = regB.origAFpu;
	assign fpu2Reg    = regB.fpu2Reg;
	assign fWriteData = regB.fWriteData;
	assign write2Mem  = regB.write2Mem;
	assign fpStart    = regB.fpStart;
	assign pcOrUtvec  = regB.pcOrUtvec;
	assign csrWrite   = regB.csrWrite;
	assign ucause     = regB.pcOrUtvec ? controlPkg::causeIllegal : 32'd0; // Only cause raised

endmodule

`default_nettype wire

//--- verilog/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit #(
	parameter bit enableFloat  = 1'b1,
	parameter bit enableMulDiv = 1'b1
) (
	input wire logic            clk,
	input wire logic            arstN,
	input wire logic            instrValid,
	input wire logic [31:0]     instr,
	output logic                ctrlValid,
	output logic                origAAlu,
	output logic                origBAlu,
	output logic                regWrite,
	output logic                memWrite,
	output logic                memRead,
	output controlPkg::mem2RegE mem2Reg,
	output controlPkg::origPcE  origPc,
	output controlPkg::aluOpE   aluOp,
	output logic                fRegWrite,
	output controlPkg::fpuOpE   fpuOp,
	output logic                origAFpu,
	output logic                fpu2Reg,
	output logic                fWriteData,
	output logic                write2Mem,
	output logic                fpStart,
	output logic                pcOrUtvec,
	output logic                csrWrite,
	output logic [31:0]         ucause
);

	ctrlBus intBus ();
	ctrlBus fpBus ();

	intDecoder #(
		.enableMulDiv(enableMulDiv)
	) u_intDecoder (
		.instr(instr),
		.bus  (intBus)
	);

	fpDecoder #(
		.enableFloat(enableFloat)
	) u_fpDecoder (
		.instr(instr),
		.bus  (fpBus)
	);

	decodeStage u_decodeStage (
		.clk       (clk),
		.arstN     (arstN),
		.instrValid(instrValid),
		.intBus    (intBus),
		.fpBus     (fpBus),
		.ctrlValid (ctrlValid),
		.origAAlu  (origAAlu),
		.origBAlu  (origBAlu),
		.regWrite  (regWrite),
		.memWrite  (memWrite),
		.memRead   (memRead),
		.mem2Reg   (mem2Reg),
		.origPc    (origPc),
		.aluOp     (aluOp),
		.fRegWrite (fRegWrite),
		.fpuOp     (fpuOp),
		.origAFpu  (origAFpu),
		.fpu2Reg   (fpu2Reg),
		.fWriteData(fWriteData),
		.write2Mem (write2Mem),
		.fpStart   (fpStart),
		.pcOrUtvec (pcOrUtvec),
		.csrWrite  (csrWrite),
		.ucause    (ucause)
	);

endmodule

`default_nettype wire

//--- sim/controlUnit_sva.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit_sva (
	input wire logic clk,
	input wire logic arstN,
	input wire logic instrValid,
	input wire logic ctrlValid,
	input wire logic regWrite,
	input wire logic fRegWrite,
	input wire logic memWrite,
	input wire logic memRead,
	input wire logic fpStart,
	input wire logic pcOrUtvec
);

	// A trap only redirects the PC and writes the cause CSR
	trapIdle: assert property (@(posedge clk) disable iff (!arstN)
		pcOrUtvec |-> !regWrite && !fRegWrite && !memWrite && !memRead)
		else $error("Trap raised together with a register or memory enable");

	fpNoMem: assert property (@(posedge clk) disable iff (!arstN)
		fpStart |-> !memRead && !memWrite)
		else $error("FPU start together with a memory access");

	validRise: assert property (@(posedge clk) disable iff (!arstN)
		instrValid |=> ctrlValid)
		else $error("ctrlValid missing one cycle after a valid instruction");

	validFall: assert property (@(posedge clk) disable iff (!arstN)
		!instrValid |=> !ctrlValid)
		else $error("ctrlValid set one cycle after an empty slot");

endmodule

bind decodeStage controlUnit_sva svaChecks (
	.clk       (clk),
	.arstN     (arstN),
	.instrValid(instrValid),
	.ctrlValid (ctrlValid),
	.regWrite  (regWrite),
	.fRegWrite (fRegWrite),
	.memWrite  (memWrite),
	.memRead   (memRead),
	.fpStart   (fpStart),
	.pcOrUtvec (pcOrUtvec)
);

`default_nettype wire

//--- sim/controlUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb;

	localparam int resetCycles = 10;
	localparam int numRandom   = 2000;
	localparam int numTests    = 2 + 128 + 1 + 16 + 32 + 1 + 13 * 8 * 3 + numRandom + 1;
	localparam int cycleLimit  = resetCycles + numTests + 50;

	// Expected registered outputs; every idle value encodes as zero
	typedef struct packed {
		logic                ctrlValid;
		logic                origAAlu;
		logic                origBAlu;
		logic                regWrite;
		logic                memWrite;
		logic                memRead;
		controlPkg::mem2RegE mem2Reg;
		controlPkg::origPcE  origPc;
		controlPkg::aluOpE   aluOp;
		logic                fRegWrite;
		controlPkg::fpuOpE   fpuOp;
		logic                origAFpu;
		logic                fpu2Reg;
		logic                fWriteData;
		logic                write2Mem;
		logic                fpStart;
		logic                pcOrUtvec;
		logic                csrWrite;
		logic [31:0]         ucause;
	} expT;

	logic                clk;
	logic                arstN;
	logic                instrValid;
	logic [31:0]         instr;
	logic                ctrlValid, origAAlu, origBAlu, regWrite, memWrite, memRead;
	controlPkg::mem2RegE mem2Reg;
	controlPkg::origPcE  origPc;
	controlPkg::aluOpE   aluOp;
	logic                fRegWrite;
	controlPkg::fpuOpE   fpuOp;
	logic                origAFpu, fpu2Reg, fWriteData, write2Mem, fpStart;
	logic                pcOrUtvec, csrWrite;
	logic [31:0]         ucause;

	integer seed;
	int     cycles = 0;

	controlPkg::aluOpE aluByF3 [8] = '{controlPkg::opAdd, controlPkg::opSll, controlPkg::opSlt,
		controlPkg::opSltu, controlPkg::opXor, controlPkg::opSrl, controlPkg::opOr,
		controlPkg::opAnd};
	controlPkg::aluOpE mulByF3 [8] = '{controlPkg::opMul, controlPkg::opMulh,
		controlPkg::opMulhsu, controlPkg::opMulhu, controlPkg::opDiv, controlPkg::opDivu,
		controlPkg::opRem, controlPkg::opRemu};
	logic [6:0] rF7 [4] = '{7'b0000000, 7'b0100000, 7'b0000001, 7'b0000010};
	logic [6:0] fpF7 [13] = '{7'b0000000, 7'b0000100, 7'b0001000, 7'b0001100, 7'b0101100,
		7'b0010000, 7'b0010100, 7'b1010000, 7'b1100000, 7'b1101000, 7'b1110000, 7'b1111000,
		7'b0011000}; // Last one is unlisted
	logic [6:0] legalOpc [16] = '{7'b0000011, 7'b0010011, 7'b0010111, 7'b0100011, 7'b0110011,
		7'b0110111, 7'b1100011, 7'b1100111, 7'b1101111, 7'b0000111, 7'b0100111, 7'b1010011,
		7'b1010011, 7'b0110011, 7'b0010011, 7'b1010011};

	controlUnit #(
		.enableFloat (1'b1),
		.enableMulDiv(1'b1)
	) u_controlUnit (
		.clk       (clk),
		.arstN     (arstN),
		.instrValid(instrValid),
		.instr     (instr),
		.ctrlValid (ctrlValid),
		.origAAlu  (origAAlu),
		.origBAlu  (origBAlu),
		.regWrite  (regWrite),
		.memWrite  (memWrite),
		.memRead   (memRead),
		.mem2Reg   (mem2Reg),
		.origPc    (origPc),
		.aluOp     (aluOp),
		.fRegWrite (fRegWrite),
		.fpuOp     (fpuOp),
		.origAFpu  (origAFpu),
		.fpu2Reg   (fpu2Reg),
		.fWriteData(fWriteData),
		.write2Mem (write2Mem),
		.fpStart   (fpStart),
		.pcOrUtvec (pcOrUtvec),
		.csrWrite  (csrWrite),
		.ucause    (ucause)
	);

	function automatic expT refDecode(input logic valid, input logic [31:0] w);
		expT        e;
		logic       legal;
		logic       toInt;
		logic [6:0] f7;
		logic [2:0] f3;
		logic [4:0] rs2;

		f7    = w[31:25];
		f3    = w[14:12];
		rs2   = w[24:20];
		e     = '0;
		legal = 1'b1;
		toInt = 1'b0;
		e.ctrlValid = valid;
		if (valid)
		begin
			e.aluOp = controlPkg::opAdd; // Address or link add for most classes
			case (w[6:0])
				7'b0000011: // LOAD
				begin
					e.origBAlu = 1'b1;
					e.regWrite = 1'b1;
					e.memRead  = 1'b1;
					e.mem2Reg  = controlPkg::wbMem;
				end
				7'b0010011: // OP-IMM has no SUB
				begin
					e.origBAlu = 1'b1;
					e.regWrite = 1'b1;
					e.aluOp    = aluByF3[f3];
					if (f3 == 3'b101 && f7 == 7'b0100000)
						e.aluOp = controlPkg::opSra;
				end
				7'b0010111: // AUIPC
				begin
					e.origAAlu = 1'b1;
					e.origBAlu = 1'b1;
					e.regWrite = 1'b1;
				end
				7'b0100011: // STORE
				begin
					e.origBAlu = 1'b1;
					e.memWrite = 1'b1;
				end
				7'b0110011: // OP
				begin
					e.regWrite = 1'b1;
					if (f7 == 7'b0000000)
						e.aluOp = aluByF3[f3];
					else if (f7 == 7'b0100000)
						e.aluOp = (f3 == 3'b000) ? controlPkg::opSub :
							(f3 == 3'b101) ? controlPkg::opSra : aluByF3[f3];
					else if (f7 == 7'b0000001)
						e.aluOp = mulByF3[f3];
					else
						legal = 1'b0;
				end
				7'b0110111: // LUI
				begin
					e.origBAlu = 1'b1;
					e.regWrite = 1'b1;
					e.aluOp    = controlPkg::opLui;
				end
				7'b1100011: e.origPc = controlPkg::pcBranch;
				7'b1100111, 7'b1101111: // JALR and JAL
				begin
					e.regWrite = 1'b1;
					e.mem2Reg  = controlPkg::wbPc4;
					e.origPc   = w[3] ? controlPkg::pcJal : controlPkg::pcJalr;
				end
				7'b0000111: // FLW
				begin
					e.origBAlu   = 1'b1;
					e.memRead    = 1'b1;
					e.mem2Reg    = controlPkg::wbMem;
					e.fRegWrite  = 1'b1;
					e.fWriteData = 1'b1;
				end
				7'b0100111: // FSW
				begin
					e.origBAlu  = 1'b1;
					e.memWrite  = 1'b1;
					e.write2Mem = 1'b1;
				end
				7'b1010011: // OP-FP
				begin
					e.aluOp    = controlPkg::opNull;
					e.fpStart  = 1'b1;
					e.origAFpu = 1'b1;
					case (f7)
						7'b0000000: e.fpuOp = controlPkg::fopAdd;
						7'b0000100: e.fpuOp = controlPkg::fopSub;
						7'b0001000: e.fpuOp = controlPkg::fopMul;
						7'b0001100: e.fpuOp = controlPkg::fopDiv;
						7'b0101100: e.fpuOp = controlPkg::fopSqrt;
						7'b0010000:
							case (f3)
								3'b000:  e.fpuOp = controlPkg::fopSgnj;
								3'b001:  e.fpuOp = controlPkg::fopSgnjn;
								3'b010:  e.fpuOp = controlPkg::fopSgnjx;
								default: legal = 1'b0;
							endcase
						7'b0010100:
							case (f3)
								3'b000:  e.fpuOp = controlPkg::fopMin;
								3'b001:  e.fpuOp = controlPkg::fopMax;
								default: legal = 1'b0;
							endcase
						7'b1010000: // FLE, FLT, FEQ
						begin
							toInt = 1'b1;
							case (f3)
								3'b000:  e.fpuOp = controlPkg::fopCle;
								3'b001:  e.fpuOp = controlPkg::fopClt;
								3'b010:  e.fpuOp = controlPkg::fopCeq;
								default: legal = 1'b0;
							endcase
						end
						7'b1101000: // Integer source
						begin
							e.origAFpu = 1'b0;
							case (rs2)
								5'd0:    e.fpuOp = controlPkg::fopCvtSW;
								5'd1:    e.fpuOp = controlPkg::fopCvtSWu;
								default: legal = 1'b0;
							endcase
						end
						7'b1100000:
						begin
							toInt = 1'b1;
							case (rs2)
								5'd0:    e.fpuOp = controlPkg::fopCvtWS;
								5'd1:    e.fpuOp = controlPkg::fopCvtWuS;
								default: legal = 1'b0;
							endcase
						end
						7'b1110000:
						begin
							e.fpuOp = controlPkg::fopMv;
							toInt   = 1'b1;
						end
						7'b1111000:
						begin
							e.fpuOp    = controlPkg::fopMv;
							e.origAFpu = 1'b0;
						end
						default: legal = 1'b0;
					endcase
					e.regWrite  = toInt;
					e.fpu2Reg   = toInt;
					e.fRegWrite = !toInt;
				end
				default: legal = 1'b0;
			endcase
			if (!legal)
			begin
				e           = '0;
				e.ctrlValid = 1'b1;
				e.pcOrUtvec = 1'b1; // Illegal instruction trap
				e.csrWrite  = 1'b1;
				e.ucause    = 32'd2;
			end
		end
		return e;
	endfunction

	task automatic stopRun();
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic flagCheck(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic aluOpCheck(input controlPkg::aluOpE got, input controlPkg::aluOpE exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t aluOp got %s expected %s", $time, got.name(), exp.name());
			stopRun();
		end
	endtask

	task automatic fpuOpCheck(input controlPkg::fpuOpE got, input controlPkg::fpuOpE exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t fpuOp got %s expected %s", $time, got.name(), exp.name());
			stopRun();
		end
	endtask

	task automatic mem2RegCheck(input controlPkg::mem2RegE got,
		input controlPkg::mem2RegE exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t mem2Reg got %s expected %s", $time, got.name(), exp.name());
			stopRun();
		end
	endtask

	task automatic origPcCheck(input controlPkg::origPcE got, input controlPkg::origPcE exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t origPc got %s expected %s", $time, got.name(), exp.name());
			stopRun();
		end
	endtask

	task automatic causeCheck(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t ucause got %0h expected %0h", $time, got, exp);
			stopRun();
		end
	endtask

	// Called on a falling edge and returns on the next one
	task automatic sendSlot(input logic valid, input logic [31:0] word);
		instrValid = valid;
		instr      = word;
		@(negedge clk);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	initial
	begin : watchdog
		while (cycles < cycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: no result after %0d clock cycles", cycleLimit);
		stopRun();
	end

	// Expected value taken at the sampling edge and outputs checked half a cycle later
	initial
	begin : compare
		expT pending;

		forever
		begin
			@(posedge clk);
			pending = refDecode(instrValid, instr);
			@(negedge clk);
			flagCheck("ctrlValid", ctrlValid, pending.ctrlValid);
			flagCheck("origAAlu", origAAlu, pending.origAAlu);
			flagCheck("origBAlu", origBAlu, pending.origBAlu);
			flagCheck("regWrite", regWrite, pending.regWrite);
			flagCheck("memWrite", memWrite, pending.memWrite);
			flagCheck("memRead", memRead, pending.memRead);
			mem2RegCheck(mem2Reg, pending.mem2Reg);
			origPcCheck(origPc, pending.origPc);
			aluOpCheck(aluOp, pending.aluOp);
			flagCheck("fRegWrite", fRegWrite, pending.fRegWrite);
			fpuOpCheck(fpuOp, pending.fpuOp);
			flagCheck("origAFpu", origAFpu, pending.origAFpu);
			flagCheck("fpu2Reg", fpu2Reg, pending.fpu2Reg);
			flagCheck("fWriteData", fWriteData, pending.fWriteData);
			flagCheck("write2Mem", write2Mem, pending.write2Mem);
			flagCheck("fpStart", fpStart, pending.fpStart);
			flagCheck("pcOrUtvec", pcOrUtvec, pending.pcOrUtvec);
			flagCheck("csrWrite", csrWrite, pending.csrWrite);
			causeCheck(ucause, pending.ucause);
		end
	end

	initial
	begin : stimulus
		logic [31:0] w;
		logic [31:0] r;

		seed       = 87;
		arstN      = 1'b0;
		instrValid = 1'b0;
		instr      = 32'd0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		sendSlot(1'b0, 32'hffffffff); // Idle before the first valid slot
		sendSlot(1'b0, 32'h00000013);
		for (int i = 0; i < 128; i++)
		begin
			w      = $random(seed);
			w[6:0] = i[6:0];
			sendSlot(1'b1, w);
		end
		sendSlot(1'b0, 32'h0000006f);
		for (int i = 0; i < 8; i++)
		begin
			for (int j = 0; j < 2; j++)
			begin
				w          = $random(seed);
				w[6:0]     = 7'b0010011;
				w[14:12]   = i[2:0];
				w[31:25]   = rF7[j];
				sendSlot(1'b1, w);
			end
			for (int j = 0; j < 4; j++)
			begin
				w          = $random(seed);
				w[6:0]     = 7'b0110011;
				w[14:12]   = i[2:0];
				w[31:25]   = rF7[j];
				sendSlot(1'b1, w);
			end
		end
		sendSlot(1'b0, 32'h00000033);
		for (int i = 0; i < 13; i++)
			for (int j = 0; j < 8; j++)
				for (int k = 0; k < 3; k++)
				begin
					w        = $random(seed);
					w[6:0]   = 7'b1010011;
					w[14:12] = j[2:0];
					w[24:20] = k[4:0];
					w[31:25] = fpF7[i];
					sendSlot(1'b1, w);
				end
		// Three of four words get a legal opcode and one slot in eight is empty
		for (int i = 0; i < numRandom; i++)
		begin
			w = $random(seed);
			r = $random(seed);
			if (r[1:0] != 2'b00)
				w[6:0] = legalOpc[r[5:2]];
			sendSlot(r[9:7] != 3'b000, w);
		end
		sendSlot(1'b0, 32'd0);
		@(posedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
verilog/controlPkg.sv
verilog/ctrlBus.sv
verilog/intDecoder.sv
verilog/fpDecoder.sv
verilog/decodeStage.sv
verilog/controlUnit.sv
sim/controlUnit_sva.sv
sim/controlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	$(SIMBIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
